// ==== Bender.yml ====
package:
  name: geometry_transform

sources:
  # shared package and interface
  - files:
      - common/gfx_pkg.sv
      - common/vertex_stream_if.sv

  # design, in compile order
  - files:
      - verilog/vertex_serializer.sv
      - transform/rot_matrix_builder.sv
      - transform/vertex_transform.sv
      - verilog/triangle_assembler.sv
      - verilog/geometry_transform_top.sv

  # testbench
  - target: test
    files:
      - test/tb_geometry_transform.sv

// ==== common/gfx_pkg.sv ====
`default_nettype none

package gfx_pkg;

    // ----------------------------------------------------------
    // fixed-point format
    // ----------------------------------------------------------
    localparam int q_frac_bits = 16;

    typedef logic signed [31:0] q16_16_t;  // 16.16, two's complement

    localparam q16_16_t q_one = 32'sh0001_0000;

    // ----------------------------------------------------------
    // geometry types
    // ----------------------------------------------------------
    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef vec3_t vertex_t;  // position only

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // object transform, angles given as precomputed sin/cos per axis
    typedef struct packed {
        vec3_t pos;
        vec3_t rot_sin;
        vec3_t rot_cos;
    } transform_t;

    // row-major, m<row><col>
    typedef struct packed {
        q16_16_t m00;
        q16_16_t m01;
        q16_16_t m02;
        q16_16_t m10;
        q16_16_t m11;
        q16_16_t m12;
        q16_16_t m20;
        q16_16_t m21;
        q16_16_t m22;
    } rot_matrix_t;

    typedef logic [1:0] vert_idx_t;  // 0..2 within a triangle

    typedef enum logic [1:0] {
        ser_idle,
        ser_issue,
        ser_wait_done
    } ser_state_e;

    // full signed product, rescaled back to 16.16 (wraps on overflow)
    function automatic q16_16_t q_mul(input q16_16_t a, input q16_16_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return q16_16_t'(prod >>> q_frac_bits);
    endfunction

endpackage

`default_nettype wire

// ==== common/vertex_stream_if.sv ====
`default_nettype none

// one vertex per valid cycle, no back-pressure
interface vertex_stream_if;
    import gfx_pkg::*;

    vertex_t   vert;
    vert_idx_t idx;    // slot in the triangle
    logic      valid;
    logic      last;   // high with idx 2

    modport src (
        output vert,
        output idx,
        output valid,
        output last
    );

    modport dst (
        input vert,
        input idx,
        input valid,
        input last
    );

endinterface

`default_nettype wire

// ==== test/tb_geometry_transform.sv ====
`default_nettype none

module tb_geometry_transform;
    timeunit 1ns;
    timeprecision 1ps;

    import gfx_pkg::*;

    localparam int n_tri       = 2 + 40 + 8;  // two fixed cases plus random and stalled
    localparam int cycle_limit = 200 * n_tri + 100;

    logic       clk = 1'b0;
    logic       rst;
    transform_t transform;
    triangle_t  triangle;
    logic       in_valid;
    logic       in_ready;
    triangle_t  out_triangle;
    logic       out_valid;
    logic       out_ready;
    logic       busy;

    logic [31:0] lfsr;
    int          cyc = 0;
    int          n_sent = 0;
    int          n_acc = 0;
    int          n_out = 0;
    int          err_val = 0;
    int          err_proto = 0;
    triangle_t   exp_q[$];   // expected world triangles in accept order
    int          acc_q[$];   // accept edge of each
    triangle_t   held;
    triangle_t   last_out;
    logic        prev_valid = 1'b0;
    logic        hs_prev = 1'b0;

    geometry_transform_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .transform    (transform),
        .triangle     (triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------
    // random source and reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // n bit signed value sign extended to 32
    task automatic rand_fixed(input int n, output q16_16_t q);
        logic [31:0] raw;
        take_bits(n, raw);
        raw = raw << (32 - n);
        q   = $signed(raw) >>> (32 - n);
    endtask

    task automatic rand_vec(input int n, output vec3_t v);
        rand_fixed(n, v.x);
        rand_fixed(n, v.y);
        rand_fixed(n, v.z);
    endtask

    task automatic rand_triangle(output triangle_t t);
        rand_vec(25, t.v0);  // within +-256
        rand_vec(25, t.v1);
        rand_vec(25, t.v2);
    endtask

    task automatic rand_transform(output transform_t tf);
        rand_vec(27, tf.pos);      // within +-1024
        rand_vec(17, tf.rot_sin);  // within +-1.0
        rand_vec(17, tf.rot_cos);
    endtask

    // keep bits 47..16 of the 64 bit product
    function automatic q16_16_t fixed_mul(input q16_16_t a, input q16_16_t b);
        logic signed [63:0] full;
        full = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return full[47:16];
    endfunction

    function automatic vertex_t rotate_translate(input rot_matrix_t m, input vec3_t p,
                                                 input vertex_t v);
        vertex_t w;
        w.x = fixed_mul(m.m00, v.x) + fixed_mul(m.m01, v.y) + fixed_mul(m.m02, v.z) + p.x;
        w.y = fixed_mul(m.m10, v.x) + fixed_mul(m.m11, v.y) + fixed_mul(m.m12, v.z) + p.y;
        w.z = fixed_mul(m.m20, v.x) + fixed_mul(m.m21, v.y) + fixed_mul(m.m22, v.z) + p.z;
        return w;
    endfunction

    function automatic triangle_t model_world(input transform_t tf, input triangle_t t_in);
        rot_matrix_t m;
        vec3_t       s;
        vec3_t       c;
        triangle_t   t_out;
        s = tf.rot_sin;
        c = tf.rot_cos;
        m.m00 = fixed_mul(c.z, c.y);
        m.m01 = fixed_mul(fixed_mul(c.z, s.y), s.x) - fixed_mul(s.z, c.x);
        m.m02 = fixed_mul(fixed_mul(c.z, s.y), c.x) + fixed_mul(s.z, s.x);
        m.m10 = fixed_mul(s.z, c.y);
        m.m11 = fixed_mul(fixed_mul(s.z, s.y), s.x) + fixed_mul(c.z, c.x);
        m.m12 = fixed_mul(fixed_mul(s.z, s.y), c.x) - fixed_mul(c.z, s.x);
        m.m20 = -s.y;
        m.m21 = fixed_mul(c.y, s.x);
        m.m22 = fixed_mul(c.y, c.x);
        t_out.v0 = rotate_translate(m, tf.pos, t_in.v0);
        t_out.v1 = rotate_translate(m, tf.pos, t_in.v1);
        t_out.v2 = rotate_translate(m, tf.pos, t_in.v2);
        return t_out;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_val++;
    endtask

    task automatic report_protocol(input string msg);
        $display("protocol failure at %0t ns: %s", $time, msg);
        err_proto++;
    endtask

    // ----------------------------------------------------------
    // checker sampling on the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            if (hs_prev) begin
                assert (in_ready) else report_protocol("in_ready low after output handshake");
            end
            hs_prev = 1'b0;
            assert (busy == !in_ready) else report_protocol("busy is not the inverse of in_ready");
            if (in_valid && in_ready) begin
                exp_q.push_back(model_world(transform, triangle));
                acc_q.push_back(cyc);
                n_acc++;
            end
            if (out_valid && !prev_valid) begin
                held = out_triangle;
                assert (acc_q.size() != 0)
                else report_protocol("out_valid rose with no triangle accepted");
                if (acc_q.size() != 0) begin
                    assert (cyc - acc_q[0] - 1 == 6)
                    else report_protocol($sformatf("out_valid rose %0d cycles after accept",
                                                   cyc - acc_q[0] - 1));
                end
            end
            if (out_valid) begin
                assert (out_triangle == held)
                else report_mismatch("out_triangle changed while out_valid was high");
                if (!out_ready) begin
                    assert (!in_ready && busy)
                    else report_protocol("in_ready or busy wrong while output is stalled");
                end else begin
                    assert (exp_q.size() != 0)
                    else report_protocol("output handshake with no triangle outstanding");
                    if (exp_q.size() != 0) begin
                        assert (out_triangle == exp_q[0])
                        else report_mismatch($sformatf("triangle %0d got %h expected %h",
                                                       n_out, out_triangle, exp_q[0]));
                        void'(exp_q.pop_front());
                        void'(acc_q.pop_front());
                    end
                end
                if (out_ready) begin
                    last_out = out_triangle;
                    n_out++;
                    hs_prev = 1'b1;
                end
            end
            prev_valid = out_valid;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d triangles came out",
                     cyc, n_out, n_sent);
            $display("value errors: %0d, protocol errors: %0d", err_val, err_proto);
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // stimulus tasks called on a falling edge
    // ----------------------------------------------------------
    task automatic send_triangle(input transform_t tf, input triangle_t t_in);
        transform = tf;
        triangle  = t_in;
        in_valid  = 1'b1;
        while (!in_ready) @(negedge clk);  // stable up to the next edge
        @(negedge clk);                    // accept edge has passed
        in_valid = 1'b0;
        n_sent++;
    endtask

    task automatic wait_outputs();
        while (n_out < n_sent) @(negedge clk);
    endtask

    initial begin
        transform_t  tf;
        triangle_t   t_in;
        triangle_t   t_exp;
        triangle_t   decoy;
        logic [31:0] stall;
        rst       = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        transform = '0;
        triangle  = '0;
        lfsr      = 32'h2a90;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready && !out_valid && !busy)
        else report_mismatch("outputs not in reset state after reset release");

        // identity rotation and then translation only
        tf.pos     = '0;
        tf.rot_sin = '0;
        tf.rot_cos = '{x: q_one, y: q_one, z: q_one};
        rand_triangle(t_in);
        send_triangle(tf, t_in);
        wait_outputs();
        assert (last_out == t_in) else report_mismatch("identity transform changed triangle");
        rand_vec(27, tf.pos);
        rand_triangle(t_in);
        t_exp.v0 = '{x: t_in.v0.x + tf.pos.x, y: t_in.v0.y + tf.pos.y, z: t_in.v0.z + tf.pos.z};
        t_exp.v1 = '{x: t_in.v1.x + tf.pos.x, y: t_in.v1.y + tf.pos.y, z: t_in.v1.z + tf.pos.z};
        t_exp.v2 = '{x: t_in.v2.x + tf.pos.x, y: t_in.v2.y + tf.pos.y, z: t_in.v2.z + tf.pos.z};
        send_triangle(tf, t_in);
        wait_outputs();
        assert (last_out == t_exp) else report_mismatch("translation not added to vertices");

        // back to back with in_valid held high while busy
        for (int i = 0; i < 40; i++) begin
            rand_transform(tf);
            rand_triangle(t_in);
            send_triangle(tf, t_in);
        end
        wait_outputs();

        // stalled output with a decoy offered meanwhile
        out_ready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            rand_transform(tf);
            rand_triangle(t_in);
            take_bits(4, stall);
            send_triangle(tf, t_in);
            while (!out_valid) @(negedge clk);
            rand_triangle(decoy);
            triangle = decoy;
            in_valid = 1'b1;  // must not be taken
            repeat (stall) @(negedge clk);
            in_valid  = 1'b0;
            out_ready = 1'b1;
            @(negedge clk);
            out_ready = 1'b0;
        end
        out_ready = 1'b1;
        wait_outputs();
        repeat (2) @(negedge clk);

        assert (n_acc == n_sent)
        else report_protocol($sformatf("%0d triangles accepted, %0d offered", n_acc, n_sent));
        assert (exp_q.size() == 0) else report_protocol("triangles left without output");
        $display("value errors: %0d, protocol errors: %0d", err_val, err_proto);
        if (err_val == 0 && err_proto == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== transform/rot_matrix_builder.sv ====
`default_nettype none

// rotation R = Rz * Ry * Rx, captured once per triangle
module rot_matrix_builder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 accept,
    input  gfx_pkg::vec3_t       rot_sin,
    input  gfx_pkg::vec3_t       rot_cos,
    output gfx_pkg::rot_matrix_t matrix
);
    import gfx_pkg::*;

    q16_16_t   czsy;  // shared by the triple products
    q16_16_t   szsy;
    rot_matrix_t m_next;

    assign czsy = q_mul(rot_cos.z, rot_sin.y);
    assign szsy = q_mul(rot_sin.z, rot_sin.y);

    always_comb begin
        m_next.m00 = q_mul(rot_cos.z, rot_cos.y);
        m_next.m01 = q_mul(czsy, rot_sin.x) - q_mul(rot_sin.z, rot_cos.x);
        m_next.m02 = q_mul(czsy, rot_cos.x) + q_mul(rot_sin.z, rot_sin.x);

        m_next.m10 = q_mul(rot_sin.z, rot_cos.y);
        m_next.m11 = q_mul(szsy, rot_sin.x) + q_mul(rot_cos.z, rot_cos.x);
        m_next.m12 = q_mul(szsy, rot_cos.x) - q_mul(rot_cos.z, rot_sin.x);

        m_next.m20 = -rot_sin.y;
        m_next.m21 = q_mul(rot_cos.y, rot_sin.x);
        m_next.m22 = q_mul(rot_cos.y, rot_cos.x);
    end

    // ----------------------------------------------------------
    // held until the next accept
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            matrix     <= '0;
            matrix.m00 <= q_one;  // identity
            matrix.m11 <= q_one;
            matrix.m22 <= q_one;
        end else if (accept) begin
            matrix <= m_next;
        end
    end

endmodule

`default_nettype wire

// ==== transform/vertex_transform.sv ====
`default_nettype none

module vertex_transform (
    input  logic                 clk,
    input  logic                 rst,
    input  gfx_pkg::rot_matrix_t matrix,
    input  gfx_pkg::vec3_t       tr_pos,
    vertex_stream_if.dst         vs_in,
    vertex_stream_if.src         vs_out
);
    import gfx_pkg::*;

    // stage 1, one product per matrix element
    q16_16_t   s1_prod [0:2][0:2];
    vert_idx_t s1_idx;
    logic      s1_valid;
    logic      s1_last;

    // stage 2, world vertex
    vertex_t   s2_vert;
    vert_idx_t s2_idx;
    logic      s2_valid;
    logic      s2_last;

    // ----------------------------------------------------------
    // valid pipe
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= vs_in.valid;
            s2_valid <= s1_valid;
        end
    end

    // ----------------------------------------------------------
    // stage 1, multiply
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (vs_in.valid) begin
            s1_prod[0][0] <= q_mul(matrix.m00, vs_in.vert.x);
            s1_prod[0][1] <= q_mul(matrix.m01, vs_in.vert.y);
            s1_prod[0][2] <= q_mul(matrix.m02, vs_in.vert.z);
            s1_prod[1][0] <= q_mul(matrix.m10, vs_in.vert.x);
            s1_prod[1][1] <= q_mul(matrix.m11, vs_in.vert.y);
            s1_prod[1][2] <= q_mul(matrix.m12, vs_in.vert.z);
            s1_prod[2][0] <= q_mul(matrix.m20, vs_in.vert.x);
            s1_prod[2][1] <= q_mul(matrix.m21, vs_in.vert.y);
            s1_prod[2][2] <= q_mul(matrix.m22, vs_in.vert.z);
            s1_idx        <= vs_in.idx;
            s1_last       <= vs_in.last;
        end
    end

    // ----------------------------------------------------------
    // stage 2, row sums plus translation
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_vert.x <= s1_prod[0][0] + s1_prod[0][1] + s1_prod[0][2] + tr_pos.x;
            s2_vert.y <= s1_prod[1][0] + s1_prod[1][1] + s1_prod[1][2] + tr_pos.y;
            s2_vert.z <= s1_prod[2][0] + s1_prod[2][1] + s1_prod[2][2] + tr_pos.z;
            s2_idx    <= s1_idx;
            s2_last   <= s1_last;
        end
    end

    assign vs_out.vert  = s2_vert;
    assign vs_out.idx   = s2_idx;
    assign vs_out.valid = s2_valid;
    assign vs_out.last  = s2_last;  // only sampled with valid

endmodule

`default_nettype wire

// ==== verilog.f ====
common/gfx_pkg.sv
common/vertex_stream_if.sv
verilog/vertex_serializer.sv
transform/rot_matrix_builder.sv
transform/vertex_transform.sv
verilog/triangle_assembler.sv
verilog/geometry_transform_top.sv
test/tb_geometry_transform.sv

// ==== verilog/geometry_transform_top.sv ====
`default_nettype none

module geometry_transform_top (
    input  logic                clk,
    input  logic                rst,

    input  gfx_pkg::transform_t transform,
    input  gfx_pkg::triangle_t  triangle,
    input  logic                in_valid,
    output logic                in_ready,

    output gfx_pkg::triangle_t  out_triangle,
    output logic                out_valid,
    input  logic                out_ready,

    output logic                busy
);
    import gfx_pkg::*;

    logic        accept;  // triangle taken this edge
    logic        done;    // world triangle handed off
    vec3_t       tr_pos;
    rot_matrix_t matrix;

    vertex_stream_if ser_vs ();  // model space vertices
    vertex_stream_if wld_vs ();  // world space vertices

    // ----------------------------------------------------------
    // front end
    // ----------------------------------------------------------
    vertex_serializer u_serializer (
        .clk      (clk),
        .rst      (rst),
        .triangle (triangle),
        .in_valid (in_valid),
        .pos      (transform.pos),
        .in_ready (in_ready),
        .accept   (accept),
        .tr_pos   (tr_pos),
        .done     (done),
        .busy     (busy),
        .vs       (ser_vs.src)
    );

    rot_matrix_builder u_rot_matrix (
        .clk     (clk),
        .rst     (rst),
        .accept  (accept),
        .rot_sin (transform.rot_sin),
        .rot_cos (transform.rot_cos),
        .matrix  (matrix)
    );

    // ----------------------------------------------------------
    // transform and reassembly
    // ----------------------------------------------------------
    vertex_transform u_vertex_transform (
        .clk    (clk),
        .rst    (rst),
        .matrix (matrix),
        .tr_pos (tr_pos),
        .vs_in  (ser_vs.dst),
        .vs_out (wld_vs.src)
    );

    triangle_assembler u_assembler (
        .clk          (clk),
        .rst          (rst),
        .vs           (wld_vs.dst),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .done         (done)
    );

endmodule

`default_nettype wire

// ==== verilog/triangle_assembler.sv ====
`default_nettype none

module triangle_assembler (
    input  logic               clk,
    input  logic               rst,
    vertex_stream_if.dst       vs,
    output gfx_pkg::triangle_t out_triangle,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               done
);
    import gfx_pkg::*;

    triangle_t tri_q;

    assign out_triangle = tri_q;
    assign done         = out_valid && out_ready;  // handshake edge

    // ----------------------------------------------------------
    // vertex slots
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (vs.valid) begin
            case (vs.idx)
                2'd0:    tri_q.v0 <= vs.vert;
                2'd1:    tri_q.v1 <= vs.vert;
                2'd2:    tri_q.v2 <= vs.vert;
                default: ;  // unused index
            endcase
        end
    end

    // ----------------------------------------------------------
    // output valid
    // ----------------------------------------------------------
    // held until taken, slots do not change meanwhile since
    // the next triangle is only accepted after done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (vs.valid && vs.last) begin
            out_valid <= 1'b1;  // triangle complete
        end else if (done) begin
            out_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vertex_serializer.sv ====
`default_nettype none

module vertex_serializer (
    input  logic               clk,
    input  logic               rst,
    input  gfx_pkg::triangle_t triangle,
    input  logic               in_valid,
    input  gfx_pkg::vec3_t     pos,
    output logic               in_ready,
    output logic               accept,
    output gfx_pkg::vec3_t     tr_pos,
    input  logic               done,
    output logic               busy,
    vertex_stream_if.src       vs
);
    import gfx_pkg::*;

    ser_state_e state;
    vert_idx_t  cnt;        // next vertex to issue
    triangle_t  tri_q;      // held copy of the accepted triangle
    vertex_t    vert_q;
    vert_idx_t  idx_q;
    logic       valid_q;
    logic       last_q;

    assign in_ready = (state == ser_idle);
    assign accept   = in_valid && in_ready;
    assign busy     = (state != ser_idle);

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ser_idle;
            cnt     <= '0;
            idx_q   <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            case (state)
                ser_idle: begin
                    if (accept) begin
                        state <= ser_issue;
                        cnt   <= '0;
                    end
                end
                ser_issue: begin
                    valid_q <= 1'b1;
                    idx_q   <= cnt;
                    last_q  <= (cnt == 2'd2);
                    cnt     <= cnt + 2'd1;
                    if (cnt == 2'd2) begin
                        state <= ser_wait_done;  // all three issued
                    end
                end
                ser_wait_done: begin
                    if (done) state <= ser_idle;  // output taken downstream
                end
                default: state <= ser_idle;
            endcase
        end
    end

    // ----------------------------------------------------------
    // payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            tri_q  <= triangle;
            tr_pos <= pos;
        end
        if (state == ser_issue) begin
            case (cnt)
                2'd0:    vert_q <= tri_q.v0;
                2'd1:    vert_q <= tri_q.v1;
                default: vert_q <= tri_q.v2;
            endcase
        end
    end

    assign vs.vert  = vert_q;
    assign vs.idx   = idx_q;
    assign vs.valid = valid_q;
    assign vs.last  = last_q;

endmodule

`default_nettype wire
